/* design/map_pkg.sv */
`default_nettype none

package map_pkg;

   localparam int MAX_CONFIG       = 16;
   localparam int BLOCK_BYTES      = 16384;
   localparam int KBD_LAYOUT_BYTES = 512;
   localparam int SDRAM_AW         = 25;
   localparam int DDR3_AW          = 28;
   localparam int KBD_AW           = 10;
   localparam int NUM_BLOCK_ID     = 16;
   localparam int NUM_PAGES        = 64;   // 4 slots x 4 subslots x 4 blocks
   localparam int COUNT_W          = 22;   // Holds 255 blocks of 16 KiB

   typedef enum logic [2:0] {
      CONFIG_NONE,
      CONFIG_RAM,
      CONFIG_ROM,
      CONFIG_BIOS,
      CONFIG_KBD_LAYOUT
   } config_typ_t;

   typedef enum logic [2:0] {
      SLOT_TYP_EMPTY,
      SLOT_TYP_RAM,
      SLOT_TYP_MSX2_RAM,
      SLOT_TYP_ROM,
      SLOT_TYP_MAPPER
   } slot_typ_t;

   typedef enum logic {
      BLOCK_TYP_RAM,
      BLOCK_TYP_ROM
   } block_typ_t;

   typedef enum logic {
      DEST_SDRAM,
      DEST_KBD
   } copy_dest_t;

   typedef struct packed {
      config_typ_t        typ;
      logic [1:0]         slot;
      logic [1:0]         sub_slot;
      logic [1:0]         start_block;
      logic [3:0]         block_id;
      logic [7:0]         block_count;
      logic               internal_mapper;
      logic [DDR3_AW-1:0] store_address;
   } mem_entry_t;

   // Layout view keeps typ and store_address on the same bits
   typedef struct packed {
      config_typ_t        typ;
      logic [18:0]        pad;
      logic [DDR3_AW-1:0] store_address;
   } kbd_entry_t;

   typedef union packed {
      mem_entry_t mem;
      kbd_entry_t kbd;
   } cfg_word_u;

   typedef struct packed {
      logic       init;
      logic [3:0] block_id;
      logic [1:0] offset;
   } page_entry_t;

   typedef struct packed {
      block_typ_t          typ;
      logic [7:0]          block_count;
      logic [SDRAM_AW-1:0] mem_offset;
   } block_entry_t;

endpackage

`default_nettype wire

/* design/map_ifs.sv */
`default_nettype none

interface copy_if;
   import map_pkg::*;

   logic                start;
   copy_dest_t          dest;
   logic [DDR3_AW-1:0]  src_addr;
   logic [COUNT_W-1:0]  byte_count;
   logic                fill_ff;     // Write 8'hFF instead of DDR3 data
   logic                done;
   logic [SDRAM_AW-1:0] cursor;      // Next free SDRAM byte

   modport seq    (output start, dest, src_addr, byte_count, fill_ff, input done, cursor);
   modport copier (input start, dest, src_addr, byte_count, fill_ff, output done, cursor);
endinterface

interface table_if;
   import map_pkg::*;

   logic                clear;
   logic                fill;
   mem_entry_t          entry;
   slot_typ_t           fill_slot_typ;
   logic [SDRAM_AW-1:0] fill_offset;
   logic                clear_busy;

   modport seq    (output clear, fill, entry, fill_slot_typ, fill_offset, input clear_busy);
   modport tables (input clear, fill, entry, fill_slot_typ, fill_offset, output clear_busy);
endinterface

`default_nettype wire

/* design/config_sequencer.sv */
`default_nettype none

module config_sequencer (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                update_request,
   input  logic [1:0]          msx_type,
   output logic                update_ack,
   output logic                need_reset,
   output logic [3:0]          cfg_index,
   input  map_pkg::cfg_word_u  cfg_word,
   copy_if.seq                 cpy,
   table_if.seq                tbl
);
   import map_pkg::*;

   typedef enum logic [2:0] {ST_IDLE, ST_CLEAR, ST_FETCH, ST_COPY, ST_NEXT} seq_state_t;

   seq_state_t  state;
   logic        launched;         // Copy start already issued
   config_typ_t cur_typ;
   slot_typ_t   mem_slot_typ;

   assign cur_typ = cfg_word.mem.typ;

   always_comb begin
      if (cur_typ == CONFIG_ROM || cur_typ == CONFIG_BIOS) begin
         mem_slot_typ = SLOT_TYP_ROM;
      end else if (msx_type == 2'd0) begin
         mem_slot_typ = SLOT_TYP_RAM;
      end else begin
         mem_slot_typ = SLOT_TYP_MSX2_RAM;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= ST_IDLE;
         cfg_index  <= '0;
         update_ack <= 1'b0;
         need_reset <= 1'b0;
         launched   <= 1'b0;
         cpy.start  <= 1'b0;
         tbl.fill   <= 1'b0;
         tbl.clear  <= 1'b0;
      end else begin
         update_ack <= 1'b0;
         cpy.start  <= 1'b0;
         tbl.fill   <= 1'b0;
         tbl.clear  <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (update_request) begin
                  update_ack <= 1'b1;
                  need_reset <= 1'b1;
                  tbl.clear  <= 1'b1;
                  cfg_index  <= '0;
                  state      <= ST_CLEAR;
               end
            end
            ST_CLEAR: begin
               if (!tbl.clear && !tbl.clear_busy) state <= ST_FETCH;   // Busy rises a cycle late
            end
            ST_FETCH: begin
               launched <= 1'b0;
               case (cur_typ)
                  CONFIG_RAM,
                  CONFIG_ROM,
                  CONFIG_BIOS: begin
                     tbl.fill <= 1'b1;
                     state    <= ST_COPY;
                  end
                  CONFIG_KBD_LAYOUT: state <= ST_COPY;
                  default:           state <= ST_NEXT;
               endcase
            end
            ST_COPY: begin
               if (!launched) begin
                  cpy.start <= 1'b1;                // One cycle after fill
                  launched  <= 1'b1;
               end else if (cpy.done) begin
                  state <= ST_NEXT;
               end
            end
            ST_NEXT: begin
               if (cfg_index == 4'(MAX_CONFIG - 1)) begin
                  need_reset <= 1'b0;
                  state      <= ST_IDLE;
               end else begin
                  cfg_index <= cfg_index + 1'b1;
                  state     <= ST_FETCH;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Copy parameters and table entry, captured while the entry is decoded
   always_ff @(posedge clk) begin
      if (state == ST_FETCH) begin
         tbl.entry         <= cfg_word.mem;
         tbl.fill_slot_typ <= mem_slot_typ;
         tbl.fill_offset   <= cpy.cursor;
         if (cur_typ == CONFIG_KBD_LAYOUT) begin
            cpy.dest       <= DEST_KBD;
            cpy.src_addr   <= cfg_word.kbd.store_address;
            cpy.byte_count <= COUNT_W'(KBD_LAYOUT_BYTES);
            cpy.fill_ff    <= 1'b0;
         end else begin
            cpy.dest       <= DEST_SDRAM;
            cpy.src_addr   <= cfg_word.mem.store_address;
            cpy.byte_count <= COUNT_W'(cfg_word.mem.block_count * BLOCK_BYTES);
            cpy.fill_ff    <= cur_typ == CONFIG_RAM;
         end
      end
   end

   a_start_fill: assert property (@(posedge clk) disable iff (!rst_n)
      !(cpy.start && tbl.fill));

endmodule

`default_nettype wire

/* design/slot_map_tables.sv */
`default_nettype none

module slot_map_tables (
   input  logic                  clk,
   input  logic                  rst_n,
   table_if.tables               tbl,
   input  logic [1:0]            map_slot,
   input  logic [1:0]            map_subslot,
   input  logic [1:0]            map_block,
   output map_pkg::page_entry_t  map_page,
   output map_pkg::slot_typ_t    map_slot_typ,
   input  logic [3:0]            blk_id,
   output map_pkg::block_entry_t blk_entry
);
   import map_pkg::*;

   slot_typ_t    slot_typ [4];
   page_entry_t  pages    [NUM_PAGES];     // Index is {slot, subslot, block}
   block_entry_t blocks   [NUM_BLOCK_ID];

   logic         busy;
   logic [5:0]   clr_ptr;
   slot_typ_t    new_slot_typ;
   block_typ_t   new_blk_typ;

   assign tbl.clear_busy = busy;

   assign new_slot_typ = tbl.entry.internal_mapper ? SLOT_TYP_MAPPER : tbl.fill_slot_typ;
   assign new_blk_typ  = (tbl.entry.typ == CONFIG_RAM) ? BLOCK_TYP_RAM : BLOCK_TYP_ROM;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         clr_ptr <= '0;
      end else if (tbl.clear) begin
         busy    <= 1'b1;
         clr_ptr <= '0;
      end else if (busy) begin
         clr_ptr <= clr_ptr + 1'b1;
         if (clr_ptr == 6'(NUM_PAGES - 1)) busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (busy) begin
         pages[clr_ptr]         <= '0;
         slot_typ[clr_ptr[5:4]] <= SLOT_TYP_EMPTY;   // Rewritten on each of its 16 pages
      end else if (tbl.fill) begin
         slot_typ[tbl.entry.slot] <= new_slot_typ;
         for (int i = 0; i < 4; i++) begin
            // Stop at block_count and at the end of the subslot
            if (i < int'(tbl.entry.block_count) && int'(tbl.entry.start_block) + i < 4) begin
               pages[{tbl.entry.slot, tbl.entry.sub_slot, tbl.entry.start_block + 2'(i)}] <= '{
                  init:     1'b1,
                  block_id: tbl.entry.block_id,
                  offset:   2'(i)
               };
            end
         end
         blocks[tbl.entry.block_id] <= '{
            typ:         new_blk_typ,
            block_count: tbl.entry.block_count,
            mem_offset:  tbl.fill_offset
         };
      end
   end

   assign map_page     = pages[{map_slot, map_subslot, map_block}];
   assign map_slot_typ = slot_typ[map_slot];
   assign blk_entry    = blocks[blk_id];

   a_no_fill_in_clear: assert property (@(posedge clk) disable iff (!rst_n)
      tbl.fill |-> !tbl.clear_busy);

endmodule

`default_nettype wire

/* design/block_copier.sv */
`default_nettype none

module block_copier (
   input  logic                         clk,
   input  logic                         rst_n,
   copy_if.copier                       cpy,
   output logic [map_pkg::DDR3_AW-1:0]  ddr3_addr,
   output logic                         ddr3_rd,
   input  logic                         ddr3_ready,
   input  logic [7:0]                   ddr3_dout,
   output logic [map_pkg::SDRAM_AW-1:0] sdram_addr,
   output logic [7:0]                   sdram_din,
   output logic                         sdram_we,
   input  logic                         sdram_ready,
   output logic [map_pkg::KBD_AW-1:0]   kbd_addr,
   output logic [7:0]                   kbd_din,
   output logic                         kbd_we
);
   import map_pkg::*;

   typedef enum logic [1:0] {CP_IDLE, CP_READ, CP_WRITE} cp_state_t;

   cp_state_t           state;
   copy_dest_t          dest_q;
   logic [DDR3_AW-1:0]  src_q;
   logic [COUNT_W-1:0]  count_q;
   logic [COUNT_W-1:0]  cnt;           // Bytes written so far
   logic                fill_q;
   logic [7:0]          data_q;
   logic [SDRAM_AW-1:0] cursor;
   logic                wr_fire;
   logic                last_byte;
   logic                rd_valid;

   assign rd_valid  = state == CP_READ && !ddr3_rd && ddr3_ready;
   assign wr_fire   = state == CP_WRITE && (dest_q == DEST_KBD || sdram_ready);
   assign last_byte = cnt == count_q - 1'b1;

   assign ddr3_addr  = src_q + DDR3_AW'(cnt);
   assign sdram_addr = cursor;
   assign cpy.cursor = cursor;
   assign sdram_din  = fill_q ? 8'hFF : data_q;
   assign sdram_we   = wr_fire && dest_q == DEST_SDRAM;
   assign kbd_din    = data_q;
   assign kbd_we     = wr_fire && dest_q == DEST_KBD;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= CP_IDLE;
         cnt      <= '0;
         ddr3_rd  <= 1'b0;
         cpy.done <= 1'b0;
         cursor   <= '0;
         kbd_addr <= '0;
      end else begin
         ddr3_rd  <= 1'b0;
         cpy.done <= 1'b0;
         case (state)
            CP_IDLE: begin
               if (cpy.start) begin
                  cnt <= '0;
                  if (cpy.dest == DEST_KBD) kbd_addr <= '0;   // Layout always starts at 0
                  if (cpy.byte_count == '0) begin
                     cpy.done <= 1'b1;
                  end else if (cpy.fill_ff) begin
                     state <= CP_WRITE;
                  end else begin
                     ddr3_rd <= 1'b1;
                     state   <= CP_READ;
                  end
               end
            end
            CP_READ: begin
               if (rd_valid) state <= CP_WRITE;
            end
            CP_WRITE: begin
               if (wr_fire) begin
                  cnt <= cnt + 1'b1;
                  if (dest_q == DEST_SDRAM) cursor <= cursor + 1'b1;
                  else                      kbd_addr <= kbd_addr + 1'b1;
                  if (last_byte) begin
                     cpy.done <= 1'b1;
                     state    <= CP_IDLE;
                  end else if (!fill_q) begin
                     ddr3_rd <= 1'b1;                 // Next read overlaps this write
                     state   <= CP_READ;
                  end
               end
            end
            default: state <= CP_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == CP_IDLE && cpy.start) begin
         dest_q  <= cpy.dest;
         src_q   <= cpy.src_addr;
         count_q <= cpy.byte_count;
         fill_q  <= cpy.fill_ff;
      end
      if (rd_valid) data_q <= ddr3_dout;
   end

   a_we_ready: assert property (@(posedge clk) disable iff (!rst_n)
      sdram_we |-> sdram_ready);

   a_rd_busy: assert property (@(posedge clk) disable iff (!rst_n)
      ddr3_rd |-> state != CP_IDLE);

endmodule

`default_nettype wire

/* design/map_builder_top.sv */
`default_nettype none

module map_builder_top (
   input  logic                         clk,
   input  logic                         rst_n,
   // Update handshake
   input  logic                         update_request,
   output logic                         update_ack,
   output logic                         need_reset,
   input  logic [1:0]                   msx_type,
   // Config table
   output logic [3:0]                   cfg_index,
   input  map_pkg::cfg_word_u           cfg_word,
   // DDR3 source
   output logic [map_pkg::DDR3_AW-1:0]  ddr3_addr,
   output logic                         ddr3_rd,
   input  logic                         ddr3_ready,
   input  logic [7:0]                   ddr3_dout,
   // SDRAM
   output logic [map_pkg::SDRAM_AW-1:0] sdram_addr,
   output logic [7:0]                   sdram_din,
   output logic                         sdram_we,
   input  logic                         sdram_ready,
   // Keyboard RAM
   output logic [map_pkg::KBD_AW-1:0]   kbd_addr,
   output logic [7:0]                   kbd_din,
   output logic                         kbd_we,
   // Table read ports
   input  logic [1:0]                   map_slot,
   input  logic [1:0]                   map_subslot,
   input  logic [1:0]                   map_block,
   output map_pkg::page_entry_t         map_page,
   output map_pkg::slot_typ_t           map_slot_typ,
   input  logic [3:0]                   blk_id,
   output map_pkg::block_entry_t        blk_entry
);

   copy_if  cpy_bus ();
   table_if tbl_bus ();

   config_sequencer u_seq (
      .clk            (clk),
      .rst_n          (rst_n),
      .update_request (update_request),
      .msx_type       (msx_type),
      .update_ack     (update_ack),
      .need_reset     (need_reset),
      .cfg_index      (cfg_index),
      .cfg_word       (cfg_word),
      .cpy            (cpy_bus.seq),
      .tbl            (tbl_bus.seq)
   );

   slot_map_tables u_tables (
      .clk          (clk),
      .rst_n        (rst_n),
      .tbl          (tbl_bus.tables),
      .map_slot     (map_slot),
      .map_subslot  (map_subslot),
      .map_block    (map_block),
      .map_page     (map_page),
      .map_slot_typ (map_slot_typ),
      .blk_id       (blk_id),
      .blk_entry    (blk_entry)
   );

   block_copier u_copier (
      .clk         (clk),
      .rst_n       (rst_n),
      .cpy         (cpy_bus.copier),
      .ddr3_addr   (ddr3_addr),
      .ddr3_rd     (ddr3_rd),
      .ddr3_ready  (ddr3_ready),
      .ddr3_dout   (ddr3_dout),
      .sdram_addr  (sdram_addr),
      .sdram_din   (sdram_din),
      .sdram_we    (sdram_we),
      .sdram_ready (sdram_ready),
      .kbd_addr    (kbd_addr),
      .kbd_din     (kbd_din),
      .kbd_we      (kbd_we)
   );

endmodule

`default_nettype wire

/* dv/map_model.svh */
`ifndef MAP_MODEL_SVH
`define MAP_MODEL_SVH

import map_pkg::*;

cfg_word_u           cfg_tbl  [MAX_CONFIG];
page_entry_t         exp_page [NUM_PAGES];
slot_typ_t           exp_slot [4];
block_entry_t        exp_blk  [NUM_BLOCK_ID];
bit                  blk_used [NUM_BLOCK_ID];
logic [SDRAM_AW-1:0] model_cursor;
logic [SDRAM_AW+7:0] exp_sdram [$];   // {address, data} in write order
logic [KBD_AW+7:0]   exp_kbd   [$];

// Contents of the DDR3 model, a hash of the byte address
function automatic logic [7:0] ddr3_byte(logic [DDR3_AW-1:0] addr);
   logic [31:0] h;
   h = {4'h0, addr} * 32'h9e37_79b1;
   return h[31:24] ^ h[7:0];
endfunction

// Expected tables and write streams for one walk over cfg_tbl
task automatic build_model(input logic [1:0] msx);
   mem_entry_t e;
   slot_typ_t  st;
   int         nbytes;
   int         base;
   for (int p = 0; p < NUM_PAGES; p++) exp_page[p] = '0;
   for (int s = 0; s < 4; s++) exp_slot[s] = SLOT_TYP_EMPTY;
   for (int n = 0; n < MAX_CONFIG; n++) begin
      e = cfg_tbl[n].mem;
      if (e.typ == CONFIG_KBD_LAYOUT) begin
         for (int i = 0; i < KBD_LAYOUT_BYTES; i++) begin
            exp_kbd.push_back({KBD_AW'(i),
                               ddr3_byte(cfg_tbl[n].kbd.store_address + DDR3_AW'(i))});
         end
      end else if (e.typ != CONFIG_NONE) begin
         if (e.internal_mapper)                                 st = SLOT_TYP_MAPPER;
         else if (e.typ == CONFIG_ROM || e.typ == CONFIG_BIOS) st = SLOT_TYP_ROM;
         else if (msx == 2'd0)                                  st = SLOT_TYP_RAM;
         else                                                   st = SLOT_TYP_MSX2_RAM;
         exp_slot[e.slot] = st;
         base = int'(e.slot) * 16 + int'(e.sub_slot) * 4;
         for (int i = 0; i < int'(e.block_count); i++) begin
            if (int'(e.start_block) + i < 4) begin
               exp_page[base + int'(e.start_block) + i] = '{1'b1, e.block_id, 2'(i)};
            end
         end
         exp_blk[e.block_id] = '{(e.typ == CONFIG_RAM) ? BLOCK_TYP_RAM : BLOCK_TYP_ROM,
                                 e.block_count, model_cursor};
         blk_used[e.block_id] = 1'b1;
         nbytes = int'(e.block_count) * BLOCK_BYTES;
         for (int i = 0; i < nbytes; i++) begin
            exp_sdram.push_back({model_cursor + SDRAM_AW'(i),
                                 (e.typ == CONFIG_RAM) ? 8'hFF
                                    : ddr3_byte(e.store_address + DDR3_AW'(i))});
         end
         model_cursor = model_cursor + SDRAM_AW'(nbytes);   // Cursor carries over
      end
   end
endtask

`endif

/* dv/tb_top.sv */
`default_nettype none

module tb_top;
   `include "map_model.svh"

   logic                clk;
   logic                rst_n;
   logic                update_request;
   logic                update_ack;
   logic                need_reset;
   logic [1:0]          msx_type;
   logic [3:0]          cfg_index;
   cfg_word_u           cfg_word;
   logic [DDR3_AW-1:0]  ddr3_addr;
   logic                ddr3_rd;
   logic                ddr3_ready;
   logic [7:0]          ddr3_dout;
   logic [SDRAM_AW-1:0] sdram_addr;
   logic [7:0]          sdram_din;
   logic                sdram_we;
   logic                sdram_ready;
   logic [KBD_AW-1:0]   kbd_addr;
   logic [7:0]          kbd_din;
   logic                kbd_we;
   logic [1:0]          map_slot;
   logic [1:0]          map_subslot;
   logic [1:0]          map_block;
   page_entry_t         map_page;
   slot_typ_t           map_slot_typ;
   logic [3:0]          blk_id;
   block_entry_t        blk_entry;

   bit                  bp = 1'b0;           // Random ready back-pressure
   logic [DDR3_AW-1:0]  rd_addr_q = '0;
   int                  ack_count = 0;
   int                  limit_cycles = 0;

   map_builder_top dut0 (.*);

   assign cfg_word = cfg_tbl[cfg_index];     // Combinational table read

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic report_fail(input string what);
      $display("%s", what);
      $display("Regression failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
         report_fail($sformatf("[ERROR] %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_addr(input string name, input logic [SDRAM_AW-1:0] got,
                             input logic [SDRAM_AW-1:0] exp);
      if (got !== exp)
         report_fail($sformatf("[ERROR] %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_page(input string name, input page_entry_t got, input page_entry_t exp);
      if (got !== exp)
         report_fail($sformatf("[ERROR] %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_slot_typ(input string name, input slot_typ_t got, input slot_typ_t exp);
      if (got !== exp)
         report_fail($sformatf("[ERROR] %0t: %s got %s expected %s", $time, name,
                               got.name(), exp.name()));
   endtask

   task automatic check_block(input string name, input block_entry_t got,
                              input block_entry_t exp);
      if (got !== exp)
         report_fail($sformatf("[ERROR] %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   // Legal random table, unique block ids and exactly one layout entry
   task automatic make_config_table();
      logic [3:0] ids [NUM_BLOCK_ID];
      logic [3:0] tmp;
      int         j;
      int         kbd_at;
      mem_entry_t e;
      for (int i = 0; i < NUM_BLOCK_ID; i++) ids[i] = 4'(i);
      for (int i = NUM_BLOCK_ID - 1; i > 0; i--) begin
         j = $urandom_range(i, 0);
         tmp = ids[i];
         ids[i] = ids[j];
         ids[j] = tmp;
      end
      kbd_at = $urandom_range(MAX_CONFIG - 1, 0);
      for (int n = 0; n < MAX_CONFIG; n++) begin
         e.typ             = config_typ_t'($urandom_range(3, 0));   // NONE, RAM, ROM, BIOS
         e.slot            = 2'($urandom);
         e.sub_slot        = 2'($urandom);
         e.start_block     = 2'($urandom);
         e.block_id        = ids[n];
         e.block_count     = 8'($urandom_range(2, 1));
         e.internal_mapper = ($urandom_range(3, 0) == 0);
         e.store_address   = DDR3_AW'($urandom) & 28'h7ff_ffff;
         cfg_tbl[n].mem = e;
         if (n == kbd_at) cfg_tbl[n].kbd.typ = CONFIG_KBD_LAYOUT;
      end
   endtask

   // Inputs change 1 unit after the rising edge
   always @(posedge clk) begin
      #1;
      ddr3_ready  = bp ? ($urandom_range(3, 0) != 0) : 1'b1;
      sdram_ready = bp ? ($urandom_range(3, 0) != 0) : 1'b1;
      ddr3_dout   = ddr3_ready ? ddr3_byte(rd_addr_q) : ~ddr3_byte(rd_addr_q);
   end

   always @(negedge clk) begin
      logic [SDRAM_AW+7:0] s_item;
      logic [KBD_AW+7:0]   k_item;
      if (ddr3_rd) rd_addr_q = ddr3_addr;
      if (update_ack) ack_count++;
      if (sdram_we) begin
         if (!sdram_ready) report_fail("SDRAM written while sdram_ready was low");
         if (exp_sdram.size() == 0) report_fail("SDRAM written with no byte left to expect");
         s_item = exp_sdram.pop_front();
         check_addr("sdram_addr", sdram_addr, s_item[SDRAM_AW+7:8]);
         check_byte("sdram_din", sdram_din, s_item[7:0]);
      end
      if (kbd_we) begin
         if (exp_kbd.size() == 0) report_fail("Keyboard RAM written with no byte left to expect");
         k_item = exp_kbd.pop_front();
         check_addr("kbd_addr", SDRAM_AW'(kbd_addr), SDRAM_AW'(k_item[KBD_AW+7:8]));
         check_byte("kbd_din", kbd_din, k_item[7:0]);
      end
   end

   task automatic run_update();
      int acks_before;
      acks_before = ack_count;
      @(posedge clk);
      #1 update_request = 1'b1;
      do @(negedge clk); while (update_ack !== 1'b1);
      if (need_reset !== 1'b1) report_fail("need_reset did not rise together with update_ack");
      @(posedge clk);
      #1 update_request = 1'b0;
      do @(negedge clk); while (need_reset === 1'b1);
      if (exp_sdram.size() != 0 || exp_kbd.size() != 0)
         report_fail($sformatf("need_reset fell with %0d SDRAM and %0d keyboard bytes unwritten",
                               exp_sdram.size(), exp_kbd.size()));
      if (ack_count != acks_before + 1)
         report_fail($sformatf("update_ack was high %0d cycles instead of one",
                               ack_count - acks_before));
   endtask

   task automatic check_tables();
      for (int p = 0; p < NUM_PAGES; p++) begin
         @(posedge clk);
         #1;
         {map_slot, map_subslot, map_block} = 6'(p);
         blk_id = 4'(p);
         @(negedge clk);
         check_page($sformatf("map_page[%0d]", p), map_page, exp_page[p]);
         check_slot_typ($sformatf("map_slot_typ[%0d]", p / 16), map_slot_typ, exp_slot[p / 16]);
         if (p < NUM_BLOCK_ID && blk_used[p])
            check_block($sformatf("blk_entry[%0d]", p), blk_entry, exp_blk[p]);
      end
   endtask

   initial begin
      wait (limit_cycles != 0);
      repeat (limit_cycles) @(posedge clk);
      report_fail("Watchdog expired before the update walks finished");
   end

   initial begin
      int run_bytes;
      void'($urandom(32'h2dec_415e));
      rst_n          = 1'b0;
      update_request = 1'b0;
      msx_type       = 2'($urandom_range(3, 0));
      ddr3_ready     = 1'b1;
      ddr3_dout      = '0;
      sdram_ready    = 1'b1;
      map_slot       = '0;
      map_subslot    = '0;
      map_block      = '0;
      blk_id         = '0;
      model_cursor   = '0;
      make_config_table();
      build_model(msx_type);
      run_bytes = exp_sdram.size() + exp_kbd.size();
      limit_cycles = 2 * (run_bytes * 8 + MAX_CONFIG * 16 + 2 * NUM_PAGES) + 1000;
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;
      run_update();
      check_tables();
      // Second walk under back-pressure, cursor continues
      bp = 1'b1;
      build_model(msx_type);
      run_update();
      check_tables();
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
+incdir+dv
design/map_pkg.sv
design/map_ifs.sv
design/config_sequencer.sv
design/slot_map_tables.sv
design/block_copier.sv
design/map_builder_top.sv
dv/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top -o tb_sim \
   && { ./obj_dir/tb_sim > sim.log 2>&1 || true; } \
   && cat sim.log \
   && grep -q "^Regression passed$" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation did not pass"; exit 1; }
